//--- logic/smartnic_app_pkg.sv
`default_nettype none

package smartnic_app_pkg;

    // ----------------------------------------------------------------------
    // Stream geometry
    // ----------------------------------------------------------------------

    // Processor ports of the application
    localparam int NUM_PORTS     = 2;

    // Reduced data word, eight bytes per beat
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;

    // ----------------------------------------------------------------------
    // Port and destination codes
    // ----------------------------------------------------------------------

    // Ingress port code, also the ingress destination
    typedef logic [1:0] port_t;

    // Egress destination, one bit wider than the port code
    typedef logic [2:0] egr_tdest_t;

    // Host queues follow the two physical ports (codes 0 and 1)
    localparam egr_tdest_t HOST0 = 3'd2;
    localparam egr_tdest_t HOST1 = 3'd3;

    // Packet identifier carried in tuser
    typedef logic [15:0] pid_t;

    // One stream beat, all sideband fields included
    typedef struct packed {
        logic [DATA_WID-1:0]      tdata;
        logic [DATA_BYTE_WID-1:0] tkeep;
        logic                     tlast;
        port_t                    tid;
        egr_tdest_t               tdest;
        pid_t                     pid;
    } axis_beat_t;

    // Host queue code that belongs to a port
    function automatic egr_tdest_t host_dest(input int port_idx);
        egr_tdest_t dest;
        case (port_idx)
            0:       dest = HOST0;
            default: dest = HOST1;
        endcase
        return dest;
    endfunction

endpackage : smartnic_app_pkg

`default_nettype wire

//--- logic/axis_full_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module axis_full_pipe (
    input  wire logic                         core_clk,
    input  wire logic                         arst_n,

    // Upstream side
    input  wire logic                         in_valid,
    output logic                              in_ready,
    input  wire smartnic_app_pkg::axis_beat_t in_beat,

    // Downstream side
    output logic                              out_valid,
    input  wire logic                         out_ready,
    output smartnic_app_pkg::axis_beat_t      out_beat
);

    // Second entry catches the beat accepted while the output stalls
    logic                         skid_valid;
    smartnic_app_pkg::axis_beat_t skid_beat;

    logic in_xfer;
    logic load_out;
    logic load_skid;

    // Ready comes from a flop, so no combinational path upstream
    assign in_ready  = ~skid_valid;
    assign in_xfer   = in_valid & in_ready;

    // Output register is free when empty or being drained
    assign load_out  = out_ready | ~out_valid;
    assign load_skid = in_xfer & ~load_out;

    // ----------------------------------------------------------------------
    // Occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (load_out) begin
                // Skid entry drains first, otherwise take the new beat
                out_valid  <= skid_valid | in_xfer;
                skid_valid <= 1'b0;
            end else if (in_xfer) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Payload
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (load_out) begin
            out_beat <= skid_valid ? skid_beat : in_beat;
        end
        if (load_skid) begin
            skid_beat <= in_beat;
        end
    end

endmodule : axis_full_pipe

`default_nettype wire

//--- logic/igr_demux.sv
`timescale 1ns/1ns
`default_nettype none

module igr_demux #(
    parameter int PORT_IDX = 0
) (
    input  wire logic                         core_clk,
    input  wire logic                         arst_n,

    // Stream from the ingress processor stage
    input  wire logic                         in_valid,
    output logic                              in_ready,
    input  wire smartnic_app_pkg::axis_beat_t in_beat,

    // Card-to-host queue of this port
    output logic                              host_valid,
    input  wire logic                         host_ready,
    output smartnic_app_pkg::axis_beat_t      host_beat,

    // Application path
    output logic                              app_valid,
    input  wire logic                         app_ready,
    output smartnic_app_pkg::axis_beat_t      app_beat
);

    // Packet lock, set after the first beat until tlast goes through
    logic locked;
    logic lock_host;

    logic sel_host;
    logic in_xfer;

    // First beat decides, later beats follow the latched route
    assign sel_host = locked ? lock_host
                             : (in_beat.tdest == smartnic_app_pkg::host_dest(PORT_IDX));

    assign host_valid = in_valid & sel_host;
    assign app_valid  = in_valid & ~sel_host;

    // Both outputs see the same beat, only valid is steered
    assign host_beat  = in_beat;
    assign app_beat   = in_beat;

    assign in_ready   = sel_host ? host_ready : app_ready;
    assign in_xfer    = in_valid & in_ready;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            locked    <= 1'b0;
            lock_host <= 1'b0;
        end else if (in_xfer) begin
            // Single-beat packets never take the lock
            locked    <= ~in_beat.tlast;
            lock_host <= sel_host;
        end
    end

endmodule : igr_demux

`default_nettype wire

//--- logic/egr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module egr_arbiter (
    input  wire logic                         core_clk,
    input  wire logic                         arst_n,

    // Application stage output
    input  wire logic                         app_valid,
    output logic                              app_ready,
    input  wire smartnic_app_pkg::axis_beat_t app_beat,

    // Host-to-card input
    input  wire logic                         host_valid,
    output logic                              host_ready,
    input  wire smartnic_app_pkg::axis_beat_t host_beat,

    // Egress application output
    output logic                              out_valid,
    input  wire logic                         out_ready,
    output smartnic_app_pkg::axis_beat_t      out_beat
);

    // Idle when clear, locked on one input while set
    logic locked;
    logic grant_host;

    // Round-robin pointer, set when the host input has priority
    logic prio_host;

    logic sel_host;
    logic other_valid;
    logic out_xfer;
    logic last_xfer;

    // ----------------------------------------------------------------------
    // Grant selection
    // ----------------------------------------------------------------------
    always_comb begin
        if (locked) begin
            sel_host = grant_host;
        end else if (app_valid && host_valid) begin
            sel_host = prio_host;
        end else begin
            // Lone requester wins without waiting
            sel_host = host_valid;
        end
    end

    // Granted input passes straight through
    assign out_valid   = sel_host ? host_valid : app_valid;
    assign out_beat    = sel_host ? host_beat : app_beat;
    assign app_ready   = out_ready & ~sel_host;
    assign host_ready  = out_ready & sel_host;

    assign out_xfer    = out_valid & out_ready;
    assign last_xfer   = out_xfer & out_beat.tlast;
    assign other_valid = sel_host ? app_valid : host_valid;

    // ----------------------------------------------------------------------
    // Lock and pointer
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            locked     <= 1'b0;
            grant_host <= 1'b0;
            prio_host  <= 1'b0;
        end else begin
            if (last_xfer) begin
                locked <= 1'b0;
                // Hand priority over only if someone is waiting
                if (other_valid) begin
                    prio_host <= ~sel_host;
                end
            end else if (out_valid) begin
                // Hold the choice once a beat is shown, even if stalled
                locked     <= 1'b1;
                grant_host <= sel_host;
            end
        end
    end

endmodule : egr_arbiter

`default_nettype wire

//--- logic/smartnic_app_port.sv
`timescale 1ns/1ns
`default_nettype none

module smartnic_app_port #(
    parameter int PORT_IDX = 0
) (
    input  wire logic                         core_clk,
    input  wire logic                         arst_n,

    // Application ingress
    input  wire logic                         igr_valid,
    output logic                              igr_ready,
    input  wire smartnic_app_pkg::axis_beat_t igr_beat,

    // Host-to-card
    input  wire logic                         h2c_valid,
    output logic                              h2c_ready,
    input  wire smartnic_app_pkg::axis_beat_t h2c_beat,

    // Application egress
    output logic                              egr_valid,
    input  wire logic                         egr_ready,
    output smartnic_app_pkg::axis_beat_t      egr_beat,

    // Card-to-host
    output logic                              c2h_valid,
    input  wire logic                         c2h_ready,
    output smartnic_app_pkg::axis_beat_t      c2h_beat
);

    // Ingress processor stage output
    logic                         demux_valid;
    logic                         demux_ready;
    smartnic_app_pkg::axis_beat_t demux_beat;

    // Demux to application stage
    logic                         app_in_valid;
    logic                         app_in_ready;
    smartnic_app_pkg::axis_beat_t app_in_beat;

    // Application stage to egress merge
    logic                         app_out_valid;
    logic                         app_out_ready;
    smartnic_app_pkg::axis_beat_t app_out_beat;

    // Stage in place of the P4 processor
    axis_full_pipe p4_proc_igr_pipe (
        .core_clk  (core_clk),
        .arst_n    (arst_n),
        .in_valid  (igr_valid),
        .in_ready  (igr_ready),
        .in_beat   (igr_beat),
        .out_valid (demux_valid),
        .out_ready (demux_ready),
        .out_beat  (demux_beat)
    );

    igr_demux #(
        .PORT_IDX (PORT_IDX)
    ) igr_demux_inst (
        .core_clk   (core_clk),
        .arst_n     (arst_n),
        .in_valid   (demux_valid),
        .in_ready   (demux_ready),
        .in_beat    (demux_beat),
        .host_valid (c2h_valid),
        .host_ready (c2h_ready),
        .host_beat  (c2h_beat),
        .app_valid  (app_in_valid),
        .app_ready  (app_in_ready),
        .app_beat   (app_in_beat)
    );

    // Stage in place of the ingress and egress application blocks
    axis_full_pipe smartnic_app_pipe (
        .core_clk  (core_clk),
        .arst_n    (arst_n),
        .in_valid  (app_in_valid),
        .in_ready  (app_in_ready),
        .in_beat   (app_in_beat),
        .out_valid (app_out_valid),
        .out_ready (app_out_ready),
        .out_beat  (app_out_beat)
    );

    egr_arbiter egr_arbiter_inst (
        .core_clk   (core_clk),
        .arst_n     (arst_n),
        .app_valid  (app_out_valid),
        .app_ready  (app_out_ready),
        .app_beat   (app_out_beat),
        .host_valid (h2c_valid),
        .host_ready (h2c_ready),
        .host_beat  (h2c_beat),
        .out_valid  (egr_valid),
        .out_ready  (egr_ready),
        .out_beat   (egr_beat)
    );

endmodule : smartnic_app_port

`default_nettype wire

//--- logic/smartnic_app.sv
`timescale 1ns/1ns
`default_nettype none

module smartnic_app (
    input  wire logic                                    core_clk,
    input  wire logic                                    arst_n,

    // Application ingress, one stream per port
    input  wire logic [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_igr_tvalid,
    output logic      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_igr_tready,
    input  wire smartnic_app_pkg::axis_beat_t
                      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_igr_beat,

    // Host-to-card
    input  wire logic [smartnic_app_pkg::NUM_PORTS-1:0]  axis_h2c_tvalid,
    output logic      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_h2c_tready,
    input  wire smartnic_app_pkg::axis_beat_t
                      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_h2c_beat,

    // Application egress
    output logic      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_egr_tvalid,
    input  wire logic [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_egr_tready,
    output smartnic_app_pkg::axis_beat_t
                      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_app_egr_beat,

    // Card-to-host
    output logic      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_c2h_tvalid,
    input  wire logic [smartnic_app_pkg::NUM_PORTS-1:0]  axis_c2h_tready,
    output smartnic_app_pkg::axis_beat_t
                      [smartnic_app_pkg::NUM_PORTS-1:0]  axis_c2h_beat
);

    // Ingress destinations only carry a port code, upper bit forced low
    function automatic smartnic_app_pkg::egr_tdest_t widen_dest(
        input smartnic_app_pkg::egr_tdest_t dest
    );
        return smartnic_app_pkg::egr_tdest_t'(smartnic_app_pkg::port_t'(dest));
    endfunction

    // ----------------------------------------------------------------------
    // Per-port datapath
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < smartnic_app_pkg::NUM_PORTS; i++) begin : g_port
        smartnic_app_pkg::axis_beat_t igr_beat;

        always_comb begin
            igr_beat       = axis_app_igr_beat[i];
            igr_beat.tdest = widen_dest(axis_app_igr_beat[i].tdest);
        end

        smartnic_app_port #(
            .PORT_IDX (i)
        ) port_inst (
            .core_clk  (core_clk),
            .arst_n    (arst_n),
            .igr_valid (axis_app_igr_tvalid[i]),
            .igr_ready (axis_app_igr_tready[i]),
            .igr_beat  (igr_beat),
            .h2c_valid (axis_h2c_tvalid[i]),
            .h2c_ready (axis_h2c_tready[i]),
            .h2c_beat  (axis_h2c_beat[i]),
            .egr_valid (axis_app_egr_tvalid[i]),
            .egr_ready (axis_app_egr_tready[i]),
            .egr_beat  (axis_app_egr_beat[i]),
            .c2h_valid (axis_c2h_tvalid[i]),
            .c2h_ready (axis_c2h_tready[i]),
            .c2h_beat  (axis_c2h_beat[i])
        );
    end : g_port

endmodule : smartnic_app

`default_nettype wire

//--- tb/smartnic_app_tb.sv
`timescale 1ns/1ns
`default_nettype none

module smartnic_app_tb;

    localparam int        NP         = smartnic_app_pkg::NUM_PORTS;
    localparam int        PKT_COUNT  = 40;
    localparam int        WAIT_LIMIT = 20000;
    localparam bit [31:0] SEED       = 32'hb82d2107;

    logic core_clk;
    logic arst_n;

    logic [NP-1:0]                         igr_tvalid;
    logic [NP-1:0]                         igr_tready;
    smartnic_app_pkg::axis_beat_t [NP-1:0] igr_beat;
    logic [NP-1:0]                         h2c_tvalid;
    logic [NP-1:0]                         h2c_tready;
    smartnic_app_pkg::axis_beat_t [NP-1:0] h2c_beat;
    logic [NP-1:0]                         egr_tvalid;
    logic [NP-1:0]                         egr_tready;
    smartnic_app_pkg::axis_beat_t [NP-1:0] egr_beat;
    logic [NP-1:0]                         c2h_tvalid;
    logic [NP-1:0]                         c2h_tready;
    smartnic_app_pkg::axis_beat_t [NP-1:0] c2h_beat;

    // Beats of the packet being driven on each input
    smartnic_app_pkg::axis_beat_t igr_pkt [NP][$];
    smartnic_app_pkg::axis_beat_t h2c_pkt [NP][$];
    int igr_made [NP];
    int h2c_made [NP];
    int pid_seq;

    // Reference model queues
    smartnic_app_pkg::axis_beat_t exp_c2h [NP][$];
    smartnic_app_pkg::axis_beat_t app_src [NP][$];
    smartnic_app_pkg::axis_beat_t h2c_src [NP][$];

    // Monitor state
    logic [NP-1:0] igr_xfer     = '0;
    logic [NP-1:0] h2c_xfer     = '0;
    logic [NP-1:0] egr_in_pkt   = '0;
    logic [NP-1:0] egr_from_h2c = '0;
    int post_cycles = 0;
    int errors      = 0;
    int c2h_beats   = 0;
    int egr_beats   = 0;
    bit timed_out   = 1'b0;

    smartnic_app DUT (
        .core_clk            (core_clk),
        .arst_n              (arst_n),
        .axis_app_igr_tvalid (igr_tvalid),
        .axis_app_igr_tready (igr_tready),
        .axis_app_igr_beat   (igr_beat),
        .axis_h2c_tvalid     (h2c_tvalid),
        .axis_h2c_tready     (h2c_tready),
        .axis_h2c_beat       (h2c_beat),
        .axis_app_egr_tvalid (egr_tvalid),
        .axis_app_egr_tready (egr_tready),
        .axis_app_egr_beat   (egr_beat),
        .axis_c2h_tvalid     (c2h_tvalid),
        .axis_c2h_tready     (c2h_tready),
        .axis_c2h_beat       (c2h_beat)
    );

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    // Ingress codes are two bits wide, the top bit of the egress code stays low
    function automatic smartnic_app_pkg::egr_tdest_t expected_dest(
        input smartnic_app_pkg::egr_tdest_t d
    );
        return {1'b0, d[1:0]};
    endfunction

    function automatic bit all_sent();
        int p;
        bit done;
        done = 1'b1;
        for (p = 0; p < NP; p++) begin
            if (igr_made[p] < PKT_COUNT || h2c_made[p] < PKT_COUNT) done = 1'b0;
            if (igr_pkt[p].size() != 0 || h2c_pkt[p].size() != 0) done = 1'b0;
        end
        return done;
    endfunction

    function automatic bit model_empty();
        int p;
        bit empty;
        empty = 1'b1;
        for (p = 0; p < NP; p++) begin
            if (exp_c2h[p].size() != 0 || app_src[p].size() != 0) empty = 1'b0;
            if (h2c_src[p].size() != 0) empty = 1'b0;
        end
        return empty;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    // New random packet for one input, also entered in the model
    task automatic build_packet(input int p, input bit from_h2c);
        int len;
        int i;
        smartnic_app_pkg::egr_tdest_t dest;
        smartnic_app_pkg::axis_beat_t b;
        smartnic_app_pkg::axis_beat_t exp;
        len  = 1 + int'($urandom % 6);
        dest = smartnic_app_pkg::egr_tdest_t'($urandom % 4);
        for (i = 0; i < len; i++) begin
            b.tdata = {$urandom, $urandom};
            b.tkeep = '1;
            b.tlast = (i == len - 1);
            if (b.tlast) b.tkeep = b.tkeep >> ($urandom % smartnic_app_pkg::DATA_BYTE_WID);
            b.tid   = smartnic_app_pkg::port_t'(p);
            // pid holds the port, the source and a running number
            b.pid   = {1'(p), from_h2c, 14'(pid_seq)};
            if (from_h2c) begin
                b.tdest = dest;
                h2c_pkt[p].push_back(b);
                h2c_src[p].push_back(b);
            end else begin
                // Bit above the port code is noise that the DUT must drop
                b.tdest   = {1'($urandom), dest[1:0]};
                exp       = b;
                exp.tdest = expected_dest(b.tdest);
                igr_pkt[p].push_back(b);
                if (exp.tdest == smartnic_app_pkg::host_dest(p)) exp_c2h[p].push_back(exp);
                else app_src[p].push_back(exp);
            end
        end
        pid_seq++;
        if (from_h2c) h2c_made[p]++;
        else igr_made[p]++;
    endtask

    task automatic drive_port(input int p);
        egr_tready[p] = ($urandom % 4) != 0;
        c2h_tready[p] = ($urandom % 4) != 0;
        if (igr_xfer[p]) begin
            void'(igr_pkt[p].pop_front());
            igr_tvalid[p] = 1'b0;
        end
        if (!igr_tvalid[p]) begin
            if (igr_pkt[p].size() == 0 && igr_made[p] < PKT_COUNT && ($urandom % 3) == 0) begin
                build_packet(p, 1'b0);
            end
            if (igr_pkt[p].size() > 0 && ($urandom % 4) != 0) begin
                igr_tvalid[p] = 1'b1;
                igr_beat[p]   = igr_pkt[p][0];
            end
        end
        if (h2c_xfer[p]) begin
            void'(h2c_pkt[p].pop_front());
            h2c_tvalid[p] = 1'b0;
        end
        if (!h2c_tvalid[p]) begin
            if (h2c_pkt[p].size() == 0 && h2c_made[p] < PKT_COUNT && ($urandom % 3) == 0) begin
                build_packet(p, 1'b1);
            end
            if (h2c_pkt[p].size() > 0 && ($urandom % 4) != 0) begin
                h2c_tvalid[p] = 1'b1;
                h2c_beat[p]   = h2c_pkt[p][0];
            end
        end
    endtask

    initial begin
        int p;
        void'($urandom(SEED));
        igr_tvalid = '0;
        igr_beat   = '0;
        h2c_tvalid = '0;
        h2c_beat   = '0;
        egr_tready = '0;
        c2h_tready = '0;
        pid_seq    = 0;
        for (p = 0; p < NP; p++) begin
            igr_made[p] = 0;
            h2c_made[p] = 0;
        end
        forever begin
            @(negedge core_clk);
            // Inputs stay idle until one clean cycle after reset
            if (arst_n && post_cycles > 0) begin
                for (p = 0; p < NP; p++) drive_port(p);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic check_beat(
        input string name,
        input smartnic_app_pkg::axis_beat_t exp,
        input smartnic_app_pkg::axis_beat_t got
    );
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_port(input string name, input int p, input logic got);
        assert (got == 1'(p)) else begin
            errors++;
            $display("** Error at %0t ns: %s pid port expected %0d, got %0d", $time, name, p, got);
        end
    endtask

    always @(posedge core_clk) begin
        int p;
        bit head_app;
        bit head_h2c;
        if (!arst_n || post_cycles == 0) begin
            assert (egr_tvalid == '0) else begin
                errors++;
                $display("** Error at %0t ns: axis_app_egr_tvalid expected %b, got %b",
                         $time, {NP{1'b0}}, egr_tvalid);
            end
            assert (c2h_tvalid == '0) else begin
                errors++;
                $display("** Error at %0t ns: axis_c2h_tvalid expected %b, got %b",
                         $time, {NP{1'b0}}, c2h_tvalid);
            end
        end
        if (!arst_n) begin
            post_cycles = 0;
        end else begin
            post_cycles++;
            for (p = 0; p < NP; p++) begin
                igr_xfer[p] = igr_tvalid[p] & igr_tready[p];
                h2c_xfer[p] = h2c_tvalid[p] & h2c_tready[p];
                if (c2h_tvalid[p] && c2h_tready[p]) begin
                    c2h_beats++;
                    check_port($sformatf("axis_c2h_beat[%0d]", p), p, c2h_beat[p].pid[15]);
                    assert (exp_c2h[p].size() > 0) else begin
                        errors++;
                        $display("Unexpected beat with pid %h on c2h of port %0d at %0t ns",
                                 c2h_beat[p].pid, p, $time);
                    end
                    if (exp_c2h[p].size() > 0) begin
                        check_beat($sformatf("axis_c2h_beat[%0d]", p), exp_c2h[p][0], c2h_beat[p]);
                        void'(exp_c2h[p].pop_front());
                    end
                end
                if (egr_tvalid[p] && egr_tready[p]) begin
                    egr_beats++;
                    check_port($sformatf("axis_app_egr_beat[%0d]", p), p, egr_beat[p].pid[15]);
                    if (!egr_in_pkt[p]) begin
                        // First beat tells which source queue the packet comes from
                        head_app = app_src[p].size() > 0 && app_src[p][0].pid == egr_beat[p].pid;
                        head_h2c = h2c_src[p].size() > 0 && h2c_src[p][0].pid == egr_beat[p].pid;
                        assert (head_app || head_h2c) else begin
                            errors++;
                            $display("Packet pid %h on app_egr of port %0d at %0t ns heads no queue",
                                     egr_beat[p].pid, p, $time);
                        end
                        egr_from_h2c[p] = head_h2c && !head_app;
                    end
                    if (egr_from_h2c[p]) begin
                        assert (h2c_src[p].size() > 0) else begin
                            errors++;
                            $display("Extra h2c beat on app_egr of port %0d at %0t ns", p, $time);
                        end
                        if (h2c_src[p].size() > 0) begin
                            check_beat($sformatf("axis_app_egr_beat[%0d]", p), h2c_src[p][0],
                                       egr_beat[p]);
                            void'(h2c_src[p].pop_front());
                        end
                    end else begin
                        assert (app_src[p].size() > 0) else begin
                            errors++;
                            $display("Extra app beat on app_egr of port %0d at %0t ns", p, $time);
                        end
                        if (app_src[p].size() > 0) begin
                            check_beat($sformatf("axis_app_egr_beat[%0d]", p), app_src[p][0],
                                       egr_beat[p]);
                            void'(app_src[p].pop_front());
                        end
                    end
                    egr_in_pkt[p] = !egr_beat[p].tlast;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------
    initial begin
        int waited;
        arst_n = 1'b0;
        repeat (3) @(posedge core_clk);
        @(negedge core_clk);
        arst_n = 1'b1;

        waited = 0;
        while (!all_sent() && waited < WAIT_LIMIT) begin
            @(negedge core_clk);
            waited++;
        end
        assert (all_sent()) else begin
            timed_out = 1'b1;
            $display("Timeout: stimulus still pending after %0d cycles", WAIT_LIMIT);
        end

        // Drain whatever is still inside the DUT
        waited = 0;
        while (!model_empty() && waited < WAIT_LIMIT) begin
            @(negedge core_clk);
            waited++;
        end
        assert (model_empty()) else begin
            timed_out = 1'b1;
            $display("Timeout: expected beats still outstanding after %0d cycles", WAIT_LIMIT);
        end

        $display("Checked %0d c2h beats and %0d app_egr beats, %0d errors, %0d timeouts",
                 c2h_beats, egr_beats, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : smartnic_app_tb

`default_nettype wire

//--- compile.f
logic/smartnic_app_pkg.sv
logic/axis_full_pipe.sv
logic/igr_demux.sv
logic/egr_arbiter.sv
logic/smartnic_app_port.sv
logic/smartnic_app.sv
tb/smartnic_app_tb.sv

//--- Makefile
TOOL      := verilator
TOP       := smartnic_app_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --timescale 1ns/1ns -j 0
LOG       := sim.log
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
